// File: Makefile
# Verilator build and run for the clock crossing memory bridge
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_avmm_rdwr_xclk
FILELIST  ?= avmm_rdwr_xclk_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: avmm_rdwr_xclk_top.f
hw/avmm_rdwr_pkg.sv
hw/async_fifo.sv
hw/avmm_rdwr_async_shim.sv
hw/avmm_rdwr_mem.sv
hw/avmm_rdwr_xclk_top.sv
test/tb_avmm_rdwr_xclk.sv

// File: hw/async_fifo.sv
// Dual-clock FIFO with Gray-coded pointers and show-ahead read data
// Also reports free space on the write side for almost-full schemes

`timescale 1ns/10ps

module async_fifo #(
    parameter int DATA_BITS = 32,
    parameter int DEPTH     = 16
) (
    input  logic                   wr_clk,
    input  logic                   rd_clk,
    input  logic                   rst_n,

    input  logic                   wr_en,
    input  logic [DATA_BITS-1:0]   wr_data,
    output logic                   full,
    output logic [$clog2(DEPTH):0] space_avail,

    input  logic                   rd_en,
    output logic [DATA_BITS-1:0]   rd_data,
    output logic                   empty
);

    // Pointers carry one extra bit so that full and empty differ
    localparam int AW = $clog2(DEPTH);
    localparam int PW = AW + 1;

    logic [DATA_BITS-1:0] mem [DEPTH];

    logic [PW-1:0] wbin, wgray, wbin_next, wgray_next;
    logic [PW-1:0] rbin, rgray, rbin_next, rgray_next;
    // Two-flop synchronizers, one per crossing direction
    logic [PW-1:0] wq1_rgray, wq2_rgray;
    logic [PW-1:0] rq1_wgray, rq2_wgray;
    // Read pointer as seen from the write clock, back in binary
    logic [PW-1:0] wr_rbin;

    function automatic logic [PW-1:0] gray2bin(input logic [PW-1:0] g);
        logic [PW-1:0] b;
        b[PW-1] = g[PW-1];
        for (int i = PW - 2; i >= 0; i--)
        begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // Write side
    // A write against a full FIFO is ignored here and flagged below
    assign wbin_next  = wbin + PW'(wr_en && !full);
    assign wgray_next = wbin_next ^ (wbin_next >> 1);
    assign wr_rbin    = gray2bin(wq2_rgray);

    // Free space may lag real reads by the synchronizer delay, never the other way
    assign space_avail = PW'(DEPTH) - (wbin - wr_rbin);

    always_ff @(posedge wr_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wbin      <= '0;
            wgray     <= '0;
            wq1_rgray <= '0;
            wq2_rgray <= '0;
            // Full holds during reset so the write side looks busy
            full      <= 1'b1;
        end
        else
        begin
            wbin      <= wbin_next;
            wgray     <= wgray_next;
            wq1_rgray <= rgray;
            wq2_rgray <= wq1_rgray;
            full      <= (wbin_next - wr_rbin) == PW'(DEPTH);
        end
    end

    always_ff @(posedge wr_clk)
    begin
        if (wr_en && !full)
        begin
            mem[wbin[AW-1:0]] <= wr_data;
        end
    end

    // Read side
    assign rbin_next  = rbin + PW'(rd_en && !empty);
    assign rgray_next = rbin_next ^ (rbin_next >> 1);

    always_ff @(posedge rd_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rbin      <= '0;
            rgray     <= '0;
            rq1_wgray <= '0;
            rq2_wgray <= '0;
            empty     <= 1'b1;
        end
        else
        begin
            rbin      <= rbin_next;
            rgray     <= rgray_next;
            rq1_wgray <= wgray;
            rq2_wgray <= rq1_wgray;
            // Equal Gray pointers mean nothing left to read
            empty     <= rgray_next == rq2_wgray;
        end
    end

    // Head of the FIFO is visible before it is popped
    assign rd_data = mem[rbin[AW-1:0]];

    // The producer must respect full, for response FIFOs this rests on sizing
    a_no_overflow: assert property (@(posedge wr_clk) disable iff (!rst_n)
        wr_en |-> !full)
        else $error("async_fifo %m overflow, write while full");

    a_no_underflow: assert property (@(posedge rd_clk) disable iff (!rst_n)
        rd_en |-> !empty)
        else $error("async_fifo %m underflow, read while empty");

endmodule

// File: hw/avmm_rdwr_async_shim.sv
// Clock crossing shim for the split read/write memory bus
// Four dual-clock FIFOs, per-domain reset synchronizers and waitrequest modes

`timescale 1ns/10ps

module avmm_rdwr_async_shim #(
    parameter int COMMAND_FIFO_DEPTH        = 16,
    // Non-zero lets this many requests follow a raised waitrequest
    parameter int COMMAND_ALMFULL_THRESHOLD = 0
) (
    input  logic                    mem_master,
    input  logic                    mem_slave,
    input  logic                    rst_n,

    input  logic                    rd_read,
    input  avmm_rdwr_pkg::rd_req_t  rd_req,
    output logic                    rd_waitrequest,
    output logic                    rd_readdatavalid,
    output avmm_rdwr_pkg::rd_rsp_t  rd_rsp,

    input  logic                    wr_write,
    input  avmm_rdwr_pkg::wr_req_t  wr_req,
    output logic                    wr_waitrequest,
    output logic                    wr_writeresponsevalid,
    output avmm_rdwr_pkg::wr_rsp_t  wr_rsp,

    output logic                    slv_rd_read,
    output avmm_rdwr_pkg::rd_req_t  slv_rd_req,
    input  logic                    slv_rd_waitrequest,
    input  logic                    slv_rd_readdatavalid,
    input  avmm_rdwr_pkg::rd_rsp_t  slv_rd_rsp,

    output logic                    slv_wr_write,
    output avmm_rdwr_pkg::wr_req_t  slv_wr_req,
    input  logic                    slv_wr_waitrequest,
    input  logic                    slv_wr_writeresponsevalid,
    input  avmm_rdwr_pkg::wr_rsp_t  slv_wr_rsp
);

    import avmm_rdwr_pkg::*;

    localparam int SPACE_WIDTH = $clog2(COMMAND_FIFO_DEPTH) + 1;

    logic [1:0] mst_rst_sync, slv_rst_sync;
    logic       mst_rst_n, slv_rst_n;

    logic                   rd_cmd_push, rd_cmd_full, rd_cmd_empty;
    logic                   wr_cmd_push, wr_cmd_full, wr_cmd_empty;
    logic [SPACE_WIDTH-1:0] rd_cmd_space, wr_cmd_space;
    logic                   rd_rsp_empty, wr_rsp_empty;
    rd_rsp_t                rd_rsp_head;
    wr_rsp_t                wr_rsp_head;

    // Reset asserts at once and is released on each clock separately
    always_ff @(posedge mem_master or negedge rst_n)
    begin
        if (!rst_n)
            mst_rst_sync <= '0;
        else
            mst_rst_sync <= {mst_rst_sync[0], 1'b1};
    end

    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
            slv_rst_sync <= '0;
        else
            slv_rst_sync <= {slv_rst_sync[0], 1'b1};
    end

    assign mst_rst_n = mst_rst_sync[1];
    assign slv_rst_n = slv_rst_sync[1];

    // In both modes a command enters only if the FIFO has room
    assign rd_cmd_push = rd_read && !rd_cmd_full;
    assign wr_cmd_push = wr_write && !wr_cmd_full;

    // Each FIFO is reset from the domain of its write side
    async_fifo #(.DATA_BITS($bits(rd_req_t)), .DEPTH(COMMAND_FIFO_DEPTH)) rd_cmd_fifo (
        .wr_clk(mem_master), .rd_clk(mem_slave), .rst_n(mst_rst_n),
        .wr_en(rd_cmd_push), .wr_data(rd_req),
        .full(rd_cmd_full), .space_avail(rd_cmd_space),
        .rd_en(slv_rd_read && !slv_rd_waitrequest), .rd_data(slv_rd_req),
        .empty(rd_cmd_empty)
    );

    async_fifo #(.DATA_BITS($bits(wr_req_t)), .DEPTH(COMMAND_FIFO_DEPTH)) wr_cmd_fifo (
        .wr_clk(mem_master), .rd_clk(mem_slave), .rst_n(mst_rst_n),
        .wr_en(wr_cmd_push), .wr_data(wr_req),
        .full(wr_cmd_full), .space_avail(wr_cmd_space),
        .rd_en(slv_wr_write && !slv_wr_waitrequest), .rd_data(slv_wr_req),
        .empty(wr_cmd_empty)
    );

    // The slave sees a request whenever a command waits in the FIFO
    assign slv_rd_read  = !rd_cmd_empty;
    assign slv_wr_write = !wr_cmd_empty;

    // Responses never outnumber commands in flight, so equal depth cannot overflow
    async_fifo #(.DATA_BITS($bits(rd_rsp_t)), .DEPTH(COMMAND_FIFO_DEPTH)) rd_rsp_fifo (
        .wr_clk(mem_slave), .rd_clk(mem_master), .rst_n(slv_rst_n),
        .wr_en(slv_rd_readdatavalid), .wr_data(slv_rd_rsp),
        .full(), .space_avail(),
        .rd_en(!rd_rsp_empty), .rd_data(rd_rsp_head),
        .empty(rd_rsp_empty)
    );

    async_fifo #(.DATA_BITS($bits(wr_rsp_t)), .DEPTH(COMMAND_FIFO_DEPTH)) wr_rsp_fifo (
        .wr_clk(mem_slave), .rd_clk(mem_master), .rst_n(slv_rst_n),
        .wr_en(slv_wr_writeresponsevalid), .wr_data(slv_wr_rsp),
        .full(), .space_avail(),
        .rd_en(!wr_rsp_empty), .rd_data(wr_rsp_head),
        .empty(wr_rsp_empty)
    );

    // The master always accepts, so every non-empty cycle pops one response
    always_ff @(posedge mem_master or negedge mst_rst_n)
    begin
        if (!mst_rst_n)
        begin
            rd_readdatavalid      <= 1'b0;
            wr_writeresponsevalid <= 1'b0;
        end
        else
        begin
            rd_readdatavalid      <= !rd_rsp_empty;
            wr_writeresponsevalid <= !wr_rsp_empty;
        end
    end

    always_ff @(posedge mem_master)
    begin
        if (!rd_rsp_empty)
            rd_rsp <= rd_rsp_head;
        if (!wr_rsp_empty)
            wr_rsp <= wr_rsp_head;
    end

    generate
        if (COMMAND_ALMFULL_THRESHOLD == 0)
        begin : g_normal
            // Plain Avalon back-pressure straight from the FIFO
            assign rd_waitrequest = rd_cmd_full;
            assign wr_waitrequest = wr_cmd_full;
        end
        else
        begin : g_almfull
            localparam logic [SPACE_WIDTH-1:0] THRESH = SPACE_WIDTH'(COMMAND_ALMFULL_THRESHOLD);

            // Space is judged after this cycle's push, leaving room for THRESH more
            always_ff @(posedge mem_master or negedge mst_rst_n)
            begin
                if (!mst_rst_n)
                begin
                    rd_waitrequest <= 1'b1;
                    wr_waitrequest <= 1'b1;
                end
                else
                begin
                    rd_waitrequest <= rd_cmd_full ||
                        ((rd_cmd_space - SPACE_WIDTH'(rd_cmd_push)) <= THRESH);
                    wr_waitrequest <= wr_cmd_full ||
                        ((wr_cmd_space - SPACE_WIDTH'(wr_cmd_push)) <= THRESH);
                end
            end

            // A request meeting a full FIFO means the master ran past its allowance
            a_no_dropped_read: assert property (@(posedge mem_master) disable iff (!mst_rst_n)
                rd_read |-> !rd_cmd_full)
                else $error("%m dropped read transaction");

            a_no_dropped_write: assert property (@(posedge mem_master) disable iff (!mst_rst_n)
                wr_write |-> !wr_cmd_full)
                else $error("%m dropped write transaction");
        end
    endgenerate

endmodule

// File: hw/avmm_rdwr_mem.sv
// Word-addressed memory slave on mem_slave with byte-enable writes,
// decode-error responses and a stall input for back-pressure

`timescale 1ns/10ps

module avmm_rdwr_mem #(
    parameter int MEM_WORDS = 512
) (
    input  logic                    mem_slave,
    input  logic                    rst_n,
    input  logic                    stall,

    input  logic                    slv_rd_read,
    input  avmm_rdwr_pkg::rd_req_t  slv_rd_req,
    output logic                    slv_rd_waitrequest,
    output logic                    slv_rd_readdatavalid,
    output avmm_rdwr_pkg::rd_rsp_t  slv_rd_rsp,

    input  logic                    slv_wr_write,
    input  avmm_rdwr_pkg::wr_req_t  slv_wr_req,
    output logic                    slv_wr_waitrequest,
    output logic                    slv_wr_writeresponsevalid,
    output avmm_rdwr_pkg::wr_rsp_t  slv_wr_rsp
);

    import avmm_rdwr_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
    logic                  stall_q;
    logic                  rd_accept, wr_accept;
    logic                  rd_in_range, wr_in_range;

    // Both channels stall together, one cycle after the stall input
    assign slv_rd_waitrequest = stall_q;
    assign slv_wr_waitrequest = stall_q;

    assign rd_accept   = slv_rd_read && !slv_rd_waitrequest;
    assign wr_accept   = slv_wr_write && !slv_wr_waitrequest;
    assign rd_in_range = int'(slv_rd_req.address) < MEM_WORDS;
    assign wr_in_range = int'(slv_wr_req.address) < MEM_WORDS;

    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Busy until the first clock after reset
            stall_q                   <= 1'b1;
            slv_rd_readdatavalid      <= 1'b0;
            slv_wr_writeresponsevalid <= 1'b0;
        end
        else
        begin
            stall_q                   <= stall;
            slv_rd_readdatavalid      <= rd_accept;
            slv_wr_writeresponsevalid <= wr_accept;
        end
    end

    // Contents start at zero, writes outside the array change nothing
    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int w = 0; w < MEM_WORDS; w++)
                mem[w] <= '0;
        end
        else if (wr_accept && wr_in_range)
        begin
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (slv_wr_req.byteenable[b])
                    mem[slv_wr_req.address[IDX_W-1:0]][b*8 +: 8] <= slv_wr_req.writedata[b*8 +: 8];
            end
        end
    end

    // Responses land one edge after acceptance
    always_ff @(posedge mem_slave)
    begin
        if (rd_accept)
        begin
            slv_rd_rsp.response <= rd_in_range ? rsp_okay : rsp_decode_error;
            slv_rd_rsp.readdata <= rd_in_range ? mem[slv_rd_req.address[IDX_W-1:0]] : '0;
        end
        if (wr_accept)
            slv_wr_rsp.response <= wr_in_range ? rsp_okay : rsp_decode_error;
    end

endmodule

// File: hw/avmm_rdwr_pkg.sv
// Shared widths, response codes and the request and response structs
// of the split read/write memory bus

package avmm_rdwr_pkg;

    // Word address width, so the bus can reach 1024 words
    parameter int ADDR_WIDTH = 10;
    parameter int DATA_WIDTH = 32;
    // One enable per data byte
    parameter int BE_WIDTH = DATA_WIDTH / 8;

    // Response codes follow the usual Avalon encoding
    // Code 1 is reserved on the bus and never produced here
    typedef enum logic [1:0] {
        rsp_okay         = 2'd0,
        rsp_slave_error  = 2'd2,
        rsp_decode_error = 2'd3
    } avmm_rsp_e;

    // Read command, 14 bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] address;
        logic [BE_WIDTH-1:0]   byteenable;
    } rd_req_t;

    // Write command, 46 bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0] writedata;
        logic [BE_WIDTH-1:0]   byteenable;
    } wr_req_t;

    // Read response, 34 bits, the code travels next to the data
    typedef struct packed {
        avmm_rsp_e             response;
        logic [DATA_WIDTH-1:0] readdata;
    } rd_rsp_t;

    // Write response, only the code for now
    // Kept as a struct so more fields can join without touching the ports
    typedef struct packed {
        avmm_rsp_e response;
    } wr_rsp_t;

endpackage

// File: hw/avmm_rdwr_xclk_top.sv
// Top level, the clock crossing shim joined to the memory slave

`timescale 1ns/10ps

module avmm_rdwr_xclk_top #(
    parameter int COMMAND_FIFO_DEPTH        = 16,
    parameter int COMMAND_ALMFULL_THRESHOLD = 0,
    parameter int MEM_WORDS                 = 512
) (
    input  logic                    mem_master,
    input  logic                    mem_slave,
    input  logic                    rst_n,
    input  logic                    stall,

    input  logic                    rd_read,
    input  avmm_rdwr_pkg::rd_req_t  rd_req,
    output logic                    rd_waitrequest,
    output logic                    rd_readdatavalid,
    output avmm_rdwr_pkg::rd_rsp_t  rd_rsp,

    input  logic                    wr_write,
    input  avmm_rdwr_pkg::wr_req_t  wr_req,
    output logic                    wr_waitrequest,
    output logic                    wr_writeresponsevalid,
    output avmm_rdwr_pkg::wr_rsp_t  wr_rsp
);

    import avmm_rdwr_pkg::*;

    // Slave-side bus on mem_slave
    logic    slv_rd_read, slv_rd_waitrequest, slv_rd_readdatavalid;
    logic    slv_wr_write, slv_wr_waitrequest, slv_wr_writeresponsevalid;
    rd_req_t slv_rd_req;
    rd_rsp_t slv_rd_rsp;
    wr_req_t slv_wr_req;
    wr_rsp_t slv_wr_rsp;

    avmm_rdwr_async_shim #(
        .COMMAND_FIFO_DEPTH(COMMAND_FIFO_DEPTH),
        .COMMAND_ALMFULL_THRESHOLD(COMMAND_ALMFULL_THRESHOLD)
    ) shim (.*);

    avmm_rdwr_mem #(.MEM_WORDS(MEM_WORDS)) mem (.*);

endmodule

// File: test/tb_avmm_rdwr_xclk.sv
// Testbench for the clock crossing bridge and its memory slave
// Holds the clocks, reset, LFSR, stimulus table, reference memory and timed waits

`timescale 1ns/10ps

module tb_avmm_rdwr_xclk;

    import avmm_rdwr_pkg::*;

    localparam int FIFO_DEPTH    = 8;
    localparam int ALMFULL       = 2;
    localparam int MEM_WORDS     = 512;
    localparam int MASTER_PERIOD = 100;
    localparam int SLAVE_PERIOD  = 70;
    localparam int DRIVE_DELAY   = 5;
    // Cycle limit for every counted wait
    localparam int WAIT_LIMIT    = 200;
    // First word address of the back-pressure writes
    localparam int BP_BASE       = 32;

    typedef enum logic {op_write, op_read} op_e;

    // One row of the stimulus table with its expected values from the reference memory
    typedef struct packed {
        op_e                   op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [BE_WIDTH-1:0]   be;
        avmm_rsp_e             exp_rsp;
        logic [DATA_WIDTH-1:0] exp_data;
    } entry_t;

    logic    mem_master, mem_slave, rst_n, stall;
    logic    rd_read, rd_waitrequest, rd_readdatavalid;
    logic    wr_write, wr_waitrequest, wr_writeresponsevalid;
    rd_req_t rd_req;
    rd_rsp_t rd_rsp;
    wr_req_t wr_req;
    wr_rsp_t wr_rsp;

    logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
    logic [15:0]           lfsr_state;
    entry_t                stim_q[$];
    string                 name_q[$];
    rd_rsp_t               rd_got_q[$];
    wr_rsp_t               wr_got_q[$];

    avmm_rdwr_xclk_top #(
        .COMMAND_FIFO_DEPTH(FIFO_DEPTH),
        .COMMAND_ALMFULL_THRESHOLD(ALMFULL),
        .MEM_WORDS(MEM_WORDS)
    ) uut (.*);

    initial
    begin
        mem_master = 1'b0;
        forever #(MASTER_PERIOD / 2) mem_master = ~mem_master;
    end

    initial
    begin
        mem_slave = 1'b0;
        forever #(SLAVE_PERIOD / 2) mem_slave = ~mem_slave;
    end

    // Valids are one master cycle wide, so the falling edge sees each exactly once
    always @(negedge mem_master)
    begin
        if (rst_n && rd_readdatavalid)
            rd_got_q.push_back(rd_rsp);
        if (rst_n && wr_writeresponsevalid)
            wr_got_q.push_back(wr_rsp);
    end

    // Galois LFSR with 16 bits of state that shifts right
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++)
        begin
            v[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic in_range(input logic [ADDR_WIDTH-1:0] addr);
        return int'(addr) < MEM_WORDS;
    endfunction

    // Merges the enabled bytes and ignores addresses past the array
    function automatic void ref_write(input logic [ADDR_WIDTH-1:0] addr,
                                      input logic [DATA_WIDTH-1:0] data,
                                      input logic [BE_WIDTH-1:0] be);
        if (in_range(addr))
        begin
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (be[b])
                    ref_mem[addr][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endfunction

    function automatic logic [DATA_WIDTH-1:0] ref_read(input logic [ADDR_WIDTH-1:0] addr);
        return in_range(addr) ? ref_mem[addr] : '0;
    endfunction

    function automatic void add_entry(input string name, input op_e op,
                                      input logic [ADDR_WIDTH-1:0] addr,
                                      input logic [DATA_WIDTH-1:0] data,
                                      input logic [BE_WIDTH-1:0] be);
        entry_t e;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.be       = be;
        e.exp_rsp  = in_range(addr) ? rsp_okay : rsp_decode_error;
        e.exp_data = (op == op_read) ? ref_read(addr) : '0;
        if (op == op_write)
            ref_write(addr, data, be);
        stim_q.push_back(e);
        name_q.push_back(name);
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Timed out waiting for %s", what);
    endtask

    // All driving and sampling happens a few ns after the master edge
    task automatic next_cycle();
        @(posedge mem_master);
        #(DRIVE_DELAY);
    endtask

    task automatic issue_write(input logic [ADDR_WIDTH-1:0] addr,
                               input logic [DATA_WIDTH-1:0] data,
                               input logic [BE_WIDTH-1:0] be);
        int n;
        n = 0;
        while (wr_waitrequest)
        begin
            next_cycle();
            n = n + 1;
            if (n > WAIT_LIMIT)
                fail_timeout("wr_waitrequest to fall");
        end
        wr_write          = 1'b1;
        wr_req.address    = addr;
        wr_req.writedata  = data;
        wr_req.byteenable = be;
        next_cycle();
        wr_write = 1'b0;
    endtask

    // Back-to-back calls keep rd_read high without a gap
    task automatic issue_read(input logic [ADDR_WIDTH-1:0] addr);
        int n;
        n = 0;
        while (rd_waitrequest)
        begin
            next_cycle();
            n = n + 1;
            if (n > WAIT_LIMIT)
                fail_timeout("rd_waitrequest to fall");
        end
        rd_read           = 1'b1;
        rd_req.address    = addr;
        rd_req.byteenable = '1;
        next_cycle();
        rd_read = 1'b0;
    endtask

    task automatic wait_rd_rsp(input int count);
        int n;
        n = 0;
        while (rd_got_q.size() < count)
        begin
            next_cycle();
            n = n + 1;
            if (n > WAIT_LIMIT)
                fail_timeout("read responses");
        end
    endtask

    task automatic wait_wr_rsp(input int count);
        int n;
        n = 0;
        while (wr_got_q.size() < count)
        begin
            next_cycle();
            n = n + 1;
            if (n > WAIT_LIMIT)
                fail_timeout("write responses");
        end
    endtask

    initial
    begin
        entry_t                e;
        rd_rsp_t               got_r;
        wr_rsp_t               got_w;
        logic [ADDR_WIDTH-1:0] ord_addr_q[$];
        logic [ADDR_WIDTH-1:0] bp_addr_q[$];
        logic [DATA_WIDTH-1:0] d;
        int                    accepted;
        int                    extra;
        int                    n;

        rst_n      = 1'b0;
        stall      = 1'b0;
        rd_read    = 1'b0;
        wr_write   = 1'b0;
        rd_req     = '0;
        wr_req     = '0;
        lfsr_state = 16'd14169;
        for (int i = 0; i < MEM_WORDS; i++)
            ref_mem[i] = '0;

        // Expected values come from the reference memory as each row is added
        add_entry("full_write", op_write, 10'd5, rand_bits(32), 4'hF);
        add_entry("full_read", op_read, 10'd5, '0, 4'hF);
        add_entry("be_0101_write", op_write, 10'd5, rand_bits(32), 4'b0101);
        add_entry("be_0101_read", op_read, 10'd5, '0, 4'hF);
        add_entry("be_1000_write", op_write, 10'd6, rand_bits(32), 4'b1000);
        add_entry("be_1000_read", op_read, 10'd6, '0, 4'hF);
        add_entry("be_0011_write", op_write, 10'd200, rand_bits(32), 4'b0011);
        add_entry("be_0011_read", op_read, 10'd200, '0, 4'hF);
        // 517 shares its low index bits with word 5, so aliasing would show up there
        add_entry("oor_write", op_write, 10'd517, rand_bits(32), 4'hF);
        add_entry("oor_read", op_read, 10'd517, '0, 4'hF);
        add_entry("oor_keeps_word", op_read, 10'd5, '0, 4'hF);
        add_entry("oor_high_read", op_read, 10'd1023, '0, 4'hF);
        for (int a = 16; a < 24; a++)
            add_entry("preload_write", op_write, ADDR_WIDTH'(a), rand_bits(32), 4'hF);

        // Both waitrequests stay high through reset until the synchronizers release
        for (int c = 0; c < 4; c++)
        begin
            next_cycle();
            if (c == 2)
                rst_n = 1'b1;
            check("reset_rd_waitrequest", 1, rd_waitrequest);
            check("reset_wr_waitrequest", 1, wr_waitrequest);
            check("reset_rd_readdatavalid", 0, rd_readdatavalid);
            check("reset_wr_writeresponsevalid", 0, wr_writeresponsevalid);
        end

        for (int i = 0; i < stim_q.size(); i++)
        begin
            e = stim_q[i];
            if (e.op == op_write)
            begin
                issue_write(e.addr, e.data, e.be);
                wait_wr_rsp(1);
                got_w = wr_got_q.pop_front();
                check({name_q[i], " response"}, e.exp_rsp, got_w.response);
            end
            else
            begin
                issue_read(e.addr);
                wait_rd_rsp(1);
                got_r = rd_got_q.pop_front();
                check({name_q[i], " response"}, e.exp_rsp, got_r.response);
                check({name_q[i], " data"}, e.exp_data, got_r.readdata);
            end
        end

        // Twelve reads go out back to back to the preloaded words and must return in order
        for (int i = 0; i < 12; i++)
            ord_addr_q.push_back(ADDR_WIDTH'(16) + ADDR_WIDTH'(rand_bits(3)));
        for (int i = 0; i < 12; i++)
            issue_read(ord_addr_q[i]);
        wait_rd_rsp(12);
        for (int i = 0; i < 12; i++)
        begin
            got_r = rd_got_q.pop_front();
            check("order_response", rsp_okay, got_r.response);
            check("order_data", ref_read(ord_addr_q[i]), got_r.readdata);
        end

        // Hold the slave stalled and give it time to register stall on its own edge
        stall = 1'b1;
        next_cycle();
        next_cycle();
        accepted = 0;
        extra    = 0;
        n        = 0;
        while (!(wr_waitrequest && extra == ALMFULL))
        begin
            n = n + 1;
            if (n > WAIT_LIMIT)
                fail_timeout("wr_waitrequest to rise under stall");
            // Writes after waitrequest rises use the almost-full allowance
            if (wr_waitrequest)
                extra = extra + 1;
            d                 = rand_bits(32);
            wr_write          = 1'b1;
            wr_req.address    = ADDR_WIDTH'(BP_BASE + accepted);
            wr_req.writedata  = d;
            wr_req.byteenable = 4'hF;
            ref_write(ADDR_WIDTH'(BP_BASE + accepted), d, 4'hF);
            bp_addr_q.push_back(ADDR_WIDTH'(BP_BASE + accepted));
            accepted = accepted + 1;
            next_cycle();
        end
        wr_write = 1'b0;
        // With the slave stalled the FIFO holds exactly its depth
        check("bp_accepted", FIFO_DEPTH, accepted);
        stall = 1'b0;
        wait_wr_rsp(accepted);
        for (int i = 0; i < accepted; i++)
        begin
            got_w = wr_got_q.pop_front();
            check("bp_write_response", rsp_okay, got_w.response);
        end
        foreach (bp_addr_q[i])
        begin
            issue_read(bp_addr_q[i]);
            wait_rd_rsp(1);
            got_r = rd_got_q.pop_front();
            check("bp_readback_response", rsp_okay, got_r.response);
            check("bp_readback_data", ref_read(bp_addr_q[i]), got_r.readdata);
        end
        // Any response beyond one per accepted request would still be queued here
        check("bp_extra_write_responses", 0, wr_got_q.size());
        check("extra_read_responses", 0, rd_got_q.size());

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
